/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes kept from RV32I
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_REQ,
        FS_DROP
    } fetch_state_t;

    localparam logic [2:0] FUNCT3_BEQ = 3'b000;
    localparam logic [2:0] FUNCT3_BNE = 3'b001;

    // addi x0, x0, 0
    localparam word_t INSTR_NOP = 32'h0000_0013;

endpackage

`default_nettype wire

/* verilog/rv_issue_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rv_issue_if
    import rv_pkg::*;
#(
    parameter int IADDR_BITS = 16
)
();

    logic                  valid;
    logic [IADDR_BITS-1:0] pc;
    alu_op_t               alu_op;
    reg_addr_t             rs1;
    reg_addr_t             rs2;
    reg_addr_t             rd;
    word_t                 imm;
    logic                  use_imm;
    logic                  reg_write;
    logic                  is_branch;
    logic                  is_jal;
    logic [2:0]            funct3;

    modport dec (
        output valid, pc, alu_op, rs1, rs2, rd, imm,
               use_imm, reg_write, is_branch, is_jal, funct3
    );

    modport exe (
        input  valid, pc, alu_op, rs1, rs2, rd, imm,
               use_imm, reg_write, is_branch, is_jal, funct3
    );

endinterface

`default_nettype wire

/* verilog/rv_fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch_ctrl
    import rv_pkg::*;
#(
    parameter int IADDR_BITS = 16
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_instr_ack,
    input  word_t                 i_instr_data,
    input  logic [IADDR_BITS-1:0] i_pc,
    input  logic                  i_redirect,
    output logic                  o_instr_req,
    output logic                  o_advance,
    output logic                  o_fetch_valid,
    output word_t                 o_fetch_instr,
    output logic [IADDR_BITS-1:0] o_fetch_pc
);

    fetch_state_t          state;
    fetch_state_t          state_next;
    logic [IADDR_BITS-1:0] drop_addr;

    always_comb
    begin
        state_next = state;
        case (state)
            FS_IDLE: state_next = FS_REQ;
            FS_REQ:
            begin
                // next address goes out right after an ack
                if (i_instr_ack)
                    state_next = FS_REQ;
                else if (i_redirect)
                    state_next = FS_DROP;
            end
            FS_DROP:
            begin
                if (i_instr_ack)
                    state_next = FS_REQ;
            end
            default: state_next = FS_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            state <= FS_IDLE;
        else
            state <= state_next;
    end

    // counter already holds the target, keep the stale address on the bus
    always_ff @(posedge i_clk)
    begin
        if (state == FS_REQ && i_redirect && !i_instr_ack)
            drop_addr <= i_pc;
    end

    assign o_instr_req   = (state != FS_IDLE);
    assign o_fetch_pc    = (state == FS_DROP) ? drop_addr : i_pc;
    assign o_advance     = (state == FS_REQ) && i_instr_ack;
    assign o_fetch_valid = (state == FS_REQ) && i_instr_ack && !i_redirect;
    assign o_fetch_instr = i_instr_data;

    a_req_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_instr_req && !i_instr_ack |=> o_instr_req && $stable(o_fetch_pc)
    );

endmodule

`default_nettype wire

/* verilog/rv_pc_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pc_counter
#(
    parameter int                    IADDR_BITS = 16,
    parameter logic [IADDR_BITS-1:0] RESET_ADDR = '0
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_advance,
    input  logic                  i_load,
    input  logic [IADDR_BITS-1:0] i_load_pc,
    output logic [IADDR_BITS-1:0] o_pc
);

    logic [IADDR_BITS-1:0] pc_q;

    // redirect wins over a step
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            pc_q <= RESET_ADDR;
        else if (i_load)
            pc_q <= i_load_pc;
        else if (i_advance)
            pc_q <= pc_q + IADDR_BITS'(4);
    end

    assign o_pc = pc_q;

    a_target_aligned: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_load |=> o_pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

/* verilog/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode
    import rv_pkg::*;
#(
    parameter int IADDR_BITS = 16
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_fetch_valid,
    input  word_t                 i_fetch_instr,
    input  logic [IADDR_BITS-1:0] i_fetch_pc,
    input  logic                  i_flush,
    output logic                  o_inv_inst,
    rv_issue_if.dec               issue
);

    word_t                 instr_q;
    logic [IADDR_BITS-1:0] pc_q;
    logic                  valid_q;
    opcode_t               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    word_t                 imm_i;
    word_t                 imm_u;
    word_t                 imm_b;
    word_t                 imm_j;
    logic                  supported;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            instr_q <= INSTR_NOP;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= i_fetch_valid && !i_flush;
            if (i_fetch_valid)
                instr_q <= i_fetch_instr;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_fetch_valid)
            pc_q <= i_fetch_pc;
    end

    assign opcode = opcode_t'(instr_q[6:0]);
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];

    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};

    always_comb
    begin
        supported       = 1'b1;
        issue.alu_op    = ALU_ADD;
        issue.imm       = imm_i;
        issue.use_imm   = 1'b0;
        issue.reg_write = 1'b0;
        issue.is_branch = 1'b0;
        issue.is_jal    = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                issue.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: issue.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: issue.alu_op = ALU_SUB;
                    {7'b0000000, 3'b100}: issue.alu_op = ALU_XOR;
                    {7'b0000000, 3'b110}: issue.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: issue.alu_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            OPC_OP_IMM:
            begin
                // only addi is kept
                issue.use_imm   = 1'b1;
                issue.reg_write = 1'b1;
                supported       = (funct3 == 3'b000);
            end
            OPC_LUI:
            begin
                issue.alu_op    = ALU_PASS_B;
                issue.imm       = imm_u;
                issue.use_imm   = 1'b1;
                issue.reg_write = 1'b1;
            end
            OPC_BRANCH:
            begin
                issue.imm       = imm_b;
                issue.is_branch = 1'b1;
                supported       = (funct3 == FUNCT3_BEQ) || (funct3 == FUNCT3_BNE);
            end
            OPC_JAL:
            begin
                issue.imm       = imm_j;
                issue.is_jal    = 1'b1;
                issue.reg_write = 1'b1;
            end
            default: supported = 1'b0;
        endcase
    end

    assign issue.valid  = valid_q && supported;
    assign issue.pc     = pc_q;
    assign issue.rs1    = instr_q[19:15];
    assign issue.rs2    = instr_q[24:20];
    assign issue.rd     = instr_q[11:7];
    assign issue.funct3 = funct3;

    assign o_inv_inst = valid_q && !supported;

endmodule

`default_nettype wire

/* verilog/rv_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regs
    import rv_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    input  logic      i_we,
    input  reg_addr_t i_rd,
    input  word_t     i_wdata,
    output word_t     o_rdata1,
    output word_t     o_rdata2
);

    // x0 has no storage
    word_t mem [1:31];

    always_ff @(posedge i_clk)
    begin
        if (i_we && i_rd != '0)
            mem[i_rd] <= i_wdata;
    end

    // same-cycle write is bypassed to the readers
    assign o_rdata1 = (i_rs1 == '0)                 ? '0      :
                      (i_we && i_rd == i_rs1)        ? i_wdata :
                                                      mem[i_rs1];
    assign o_rdata2 = (i_rs2 == '0)                 ? '0      :
                      (i_we && i_rd == i_rs2)        ? i_wdata :
                                                      mem[i_rs2];

    a_write_visible: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_we && i_rd != '0 ##1 i_rs1 == $past(i_rd) && !i_we
            |-> o_rdata1 == $past(i_wdata)
    );

endmodule

`default_nettype wire

/* verilog/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute
    import rv_pkg::*;
#(
    parameter int IADDR_BITS = 16
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  word_t                 i_rdata1,
    input  word_t                 i_rdata2,
    rv_issue_if.exe               issue,
    output reg_addr_t             o_rs1,
    output reg_addr_t             o_rs2,
    output logic                  o_redirect,
    output logic [IADDR_BITS-1:0] o_redirect_pc,
    output logic                  o_wb_we,
    output reg_addr_t             o_wb_rd,
    output word_t                 o_wb_data,
    output logic                  o_retire_valid,
    output logic [IADDR_BITS-1:0] o_retire_pc
);

    word_t op_b;
    word_t alu_res;
    word_t link;
    word_t result;
    logic  equal;
    logic  cond;
    logic  go;
    logic  redirect_q;

    assign o_rs1 = issue.rs1;
    assign o_rs2 = issue.rs2;

    assign op_b = issue.use_imm ? issue.imm : i_rdata2;

    always_comb
    begin
        case (issue.alu_op)
            ALU_ADD: alu_res = i_rdata1 + op_b;
            ALU_SUB: alu_res = i_rdata1 - op_b;
            ALU_AND: alu_res = i_rdata1 & op_b;
            ALU_OR:  alu_res = i_rdata1 | op_b;
            ALU_XOR: alu_res = i_rdata1 ^ op_b;
            default: alu_res = op_b;
        endcase
    end

    assign link   = word_t'(issue.pc) + word_t'(4);
    assign result = issue.is_jal ? link : alu_res;

    // decode only lets beq and bne through
    assign equal = (i_rdata1 == i_rdata2);
    assign cond  = (issue.funct3 == FUNCT3_BNE) ? !equal : equal;

    // slot after a redirect holds nothing
    assign go            = issue.valid && !redirect_q;
    assign o_redirect    = go && (issue.is_jal || (issue.is_branch && cond));
    assign o_redirect_pc = issue.pc + issue.imm[IADDR_BITS-1:0];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            redirect_q     <= 1'b0;
            o_retire_valid <= 1'b0;
            o_wb_we        <= 1'b0;
        end
        else
        begin
            redirect_q     <= o_redirect;
            o_retire_valid <= go;
            o_wb_we        <= go && issue.reg_write;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_wb_rd     <= issue.reg_write ? issue.rd : '0;
        o_wb_data   <= issue.reg_write ? result : '0;
        o_retire_pc <= issue.pc;
    end

    a_we_needs_valid: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_wb_we |-> o_retire_valid
    );

    // the word behind a taken redirect never reaches the issue slot
    a_shadow_dropped: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_redirect |=> !issue.valid
    );

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core
#(
    parameter int                    IADDR_BITS = 16,
    parameter logic [IADDR_BITS-1:0] RESET_ADDR = '0
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    output logic                  o_instr_req,
    output logic [IADDR_BITS-1:0] o_instr_addr,
    input  logic                  i_instr_ack,
    input  rv_pkg::word_t         i_instr_data,
    output logic                  o_retire_valid,
    output logic                  o_retire_we,
    output logic [IADDR_BITS-1:0] o_retire_pc,
    output rv_pkg::reg_addr_t     o_retire_rd,
    output rv_pkg::word_t         o_retire_data,
    output logic                  o_inv_inst
);

    logic                  advance;
    logic [IADDR_BITS-1:0] pc;
    logic                  fetch_valid;
    rv_pkg::word_t         fetch_instr;
    logic                  redirect;
    logic [IADDR_BITS-1:0] redirect_pc;
    rv_pkg::reg_addr_t     rs1;
    rv_pkg::reg_addr_t     rs2;
    rv_pkg::word_t         rdata1;
    rv_pkg::word_t         rdata2;

    rv_issue_if #(.IADDR_BITS(IADDR_BITS)) issue_bus ();

    rv_fetch_ctrl #(.IADDR_BITS(IADDR_BITS)) u_fetch (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_ack   (i_instr_ack),
        .i_instr_data  (i_instr_data),
        .i_pc          (pc),
        .i_redirect    (redirect),
        .o_instr_req   (o_instr_req),
        .o_advance     (advance),
        .o_fetch_valid (fetch_valid),
        .o_fetch_instr (fetch_instr),
        .o_fetch_pc    (o_instr_addr)
    );

    rv_pc_counter #(.IADDR_BITS(IADDR_BITS), .RESET_ADDR(RESET_ADDR)) u_pc (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_advance (advance),
        .i_load    (redirect),
        .i_load_pc (redirect_pc),
        .o_pc      (pc)
    );

    rv_decode #(.IADDR_BITS(IADDR_BITS)) u_decode (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_fetch_valid (fetch_valid),
        .i_fetch_instr (fetch_instr),
        .i_fetch_pc    (o_instr_addr),
        .i_flush       (redirect),
        .o_inv_inst    (o_inv_inst),
        .issue         (issue_bus.dec)
    );

    rv_regs u_regs (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .i_we     (o_retire_we),
        .i_rd     (o_retire_rd),
        .i_wdata  (o_retire_data),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    rv_execute #(.IADDR_BITS(IADDR_BITS)) u_execute (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_rdata1       (rdata1),
        .i_rdata2       (rdata2),
        .issue          (issue_bus.exe),
        .o_rs1          (rs1),
        .o_rs2          (rs2),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_wb_we        (o_retire_we),
        .o_wb_rd        (o_retire_rd),
        .o_wb_data      (o_retire_data),
        .o_retire_valid (o_retire_valid),
        .o_retire_pc    (o_retire_pc)
    );

endmodule

`default_nettype wire

/* dv/tb_rv_program.svh */
// program image at word index addr/4, and the retire stream it has to produce

localparam int PROG_LEN     = 24;
localparam int RETIRE_COUNT = 19;
// retires seen before the unsupported word reaches decode
localparam int INV_AFTER    = 15;
localparam int INV_COUNT    = 1;

typedef struct packed {
    logic [IADDR_BITS-1:0] pc;
    logic                  we;
    reg_addr_t             rd;
    word_t                 data;
} retire_t;

word_t prog [PROG_LEN];

function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                input reg_addr_t rd, input reg_addr_t rs1,
                                input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                input reg_addr_t rd, input reg_addr_t rs1, input int imm);
    logic [11:0] v;
    v = 12'(imm);
    return {v, rs1, f3, rd, opc};
endfunction

function automatic word_t enc_u(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, OPC_LUI};
endfunction

function automatic word_t enc_b(input logic [2:0] f3, input reg_addr_t rs1,
                                input reg_addr_t rs2, input int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], OPC_BRANCH};
endfunction

function automatic word_t enc_j(input reg_addr_t rd, input int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], rd, OPC_JAL};
endfunction

task automatic load_program();
    prog[0]  = enc_i(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 5);
    prog[1]  = enc_i(OPC_OP_IMM, 3'b000, 5'd2, 5'd1, -3);
    prog[2]  = enc_u(5'd3, 20'h12345);
    prog[3]  = enc_r(7'b0000000, 3'b000, 5'd4, 5'd3, 5'd1);
    prog[4]  = enc_r(7'b0100000, 3'b000, 5'd5, 5'd1, 5'd2);
    prog[5]  = enc_r(7'b0000000, 3'b111, 5'd6, 5'd4, 5'd5);
    prog[6]  = enc_r(7'b0000000, 3'b110, 5'd7, 5'd3, 5'd2);
    prog[7]  = enc_r(7'b0000000, 3'b100, 5'd8, 5'd4, 5'd7);
    // x0 write retires but must not stick
    prog[8]  = enc_i(OPC_OP_IMM, 3'b000, 5'd0, 5'd1, 7);
    prog[9]  = enc_r(7'b0000000, 3'b000, 5'd9, 5'd0, 5'd1);
    prog[10] = enc_r(7'b0100000, 3'b000, 5'd10, 5'd2, 5'd1);
    prog[11] = enc_b(FUNCT3_BEQ, 5'd1, 5'd2, 8);
    prog[12] = enc_b(FUNCT3_BNE, 5'd1, 5'd2, 12);
    prog[13] = enc_i(OPC_OP_IMM, 3'b000, 5'd9, 5'd0, 'h111);
    prog[14] = enc_i(OPC_OP_IMM, 3'b000, 5'd9, 5'd0, 'h222);
    prog[15] = enc_b(FUNCT3_BEQ, 5'd9, 5'd1, 8);
    prog[16] = enc_i(OPC_OP_IMM, 3'b000, 5'd10, 5'd0, 'h333);
    prog[17] = enc_j(5'd13, 12);
    prog[18] = enc_i(OPC_OP_IMM, 3'b000, 5'd13, 5'd0, 'h444);
    prog[19] = enc_i(OPC_OP_IMM, 3'b000, 5'd10, 5'd0, 'h555);
    // xori is outside the subset
    prog[20] = enc_i(OPC_OP_IMM, 3'b100, 5'd14, 5'd1, 1);
    prog[21] = enc_i(OPC_OP_IMM, 3'b000, 5'd14, 5'd13, -4);
    prog[22] = enc_r(7'b0000000, 3'b000, 5'd15, 5'd9, 5'd10);
    prog[23] = enc_b(FUNCT3_BEQ, 5'd0, 5'd0, 0);
endtask

// pc, we, rd, data
localparam retire_t EXPECTED [RETIRE_COUNT] = '{
    '{16'h0000, 1'b1, 5'd1,  32'h0000_0005},
    '{16'h0004, 1'b1, 5'd2,  32'h0000_0002},
    '{16'h0008, 1'b1, 5'd3,  32'h1234_5000},
    '{16'h000c, 1'b1, 5'd4,  32'h1234_5005},
    '{16'h0010, 1'b1, 5'd5,  32'h0000_0003},
    '{16'h0014, 1'b1, 5'd6,  32'h0000_0001},
    '{16'h0018, 1'b1, 5'd7,  32'h1234_5002},
    '{16'h001c, 1'b1, 5'd8,  32'h0000_0007},
    '{16'h0020, 1'b1, 5'd0,  32'h0000_000c},
    '{16'h0024, 1'b1, 5'd9,  32'h0000_0005},
    '{16'h0028, 1'b1, 5'd10, 32'hffff_fffd},
    '{16'h002c, 1'b0, 5'd0,  32'h0000_0000},
    '{16'h0030, 1'b0, 5'd0,  32'h0000_0000},
    '{16'h003c, 1'b0, 5'd0,  32'h0000_0000},
    '{16'h0044, 1'b1, 5'd13, 32'h0000_0048},
    '{16'h0054, 1'b1, 5'd14, 32'h0000_0044},
    '{16'h0058, 1'b1, 5'd15, 32'h0000_0002},
    '{16'h005c, 1'b0, 5'd0,  32'h0000_0000},
    '{16'h005c, 1'b0, 5'd0,  32'h0000_0000}
};

/* dv/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    localparam int IADDR_BITS     = 16;
    localparam int RETIRE_TIMEOUT = 200;

    logic                  i_clk        = 1'b0;
    logic                  i_rst_n      = 1'b0;
    logic                  i_instr_ack  = 1'b0;
    word_t                 i_instr_data = '0;
    logic                  o_instr_req;
    logic [IADDR_BITS-1:0] o_instr_addr;
    logic                  o_retire_valid;
    logic                  o_retire_we;
    logic [IADDR_BITS-1:0] o_retire_pc;
    reg_addr_t             o_retire_rd;
    word_t                 o_retire_data;
    logic                  o_inv_inst;

    logic [31:0]           rng_state   = 32'ha680_6a10;
    logic                  req_open    = 1'b0;
    logic [IADDR_BITS-1:0] req_addr    = '0;
    int                    wait_left   = 0;
    int                    inv_seen    = 0;

    `include "tb_rv_program.svh"

    always #4 i_clk = ~i_clk;

    rv_core #(
        .IADDR_BITS (IADDR_BITS),
        .RESET_ADDR (16'h0000)
    ) dut0 (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .o_instr_req    (o_instr_req),
        .o_instr_addr   (o_instr_addr),
        .i_instr_ack    (i_instr_ack),
        .i_instr_data   (i_instr_data),
        .o_retire_valid (o_retire_valid),
        .o_retire_we    (o_retire_we),
        .o_retire_pc    (o_retire_pc),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data),
        .o_inv_inst     (o_inv_inst)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            report_failure($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp)
            report_failure($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // words past the program are unsupported opcodes tagged with their address
    function automatic word_t fetch_word(input logic [IADDR_BITS-1:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < PROG_LEN)
            return prog[idx];
        else
            return {addr, 16'h007f};
    endfunction

    // one request at a time, acked after 0 to 3 cycles, back to back allowed
    always @(negedge i_clk)
    begin
        if (i_instr_ack)
        begin
            i_instr_ack <= 1'b0;
            req_open = 1'b0;
        end
        if (o_instr_req)
        begin
            if (!req_open)
            begin
                req_open  = 1'b1;
                req_addr  = o_instr_addr;
                rng_state = xorshift32(rng_state);
                wait_left = int'(rng_state % 4);
            end
            else if (o_instr_addr !== req_addr)
                report_failure("instruction address changed while a request was pending");
            if (wait_left == 0)
            begin
                i_instr_ack  <= 1'b1;
                i_instr_data <= fetch_word(req_addr);
            end
            else
                wait_left = wait_left - 1;
        end
    end

    task automatic note_invalid(input int retired);
        inv_seen++;
        if (retired != INV_AFTER)
            report_failure($sformatf("invalid-instruction pulse after %0d retires, expected after %0d",
                                     retired, INV_AFTER));
    endtask

    // also watches o_inv_inst while waiting
    task automatic wait_retire(input int idx);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen)
        begin
            @(negedge i_clk);
            if (o_inv_inst)
                note_invalid(idx);
            if (o_retire_valid)
                seen = 1'b1;
            else
            begin
                cycles++;
                if (cycles > RETIRE_TIMEOUT)
                    report_failure($sformatf("no retire for entry %0d within %0d cycles",
                                             idx, RETIRE_TIMEOUT));
            end
        end
    endtask

    initial
    begin
        retire_t exp_entry;
        load_program();
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        check_bit("o_instr_req", 1'b0, o_instr_req);
        check_bit("o_retire_valid", 1'b0, o_retire_valid);
        check_bit("o_retire_we", 1'b0, o_retire_we);
        check_bit("o_inv_inst", 1'b0, o_inv_inst);
        i_rst_n = 1'b1;

        // first request in the first cycle out of reset, at the reset address
        @(negedge i_clk);
        check_bit("o_instr_req", 1'b1, o_instr_req);
        check_word("o_instr_addr", 32'h0000_0000, word_t'(o_instr_addr));

        for (int i = 0; i < RETIRE_COUNT; i++)
        begin
            wait_retire(i);
            exp_entry = EXPECTED[i];
            check_word($sformatf("o_retire_pc[%0d]", i), word_t'(exp_entry.pc),
                       word_t'(o_retire_pc));
            check_bit($sformatf("o_retire_we[%0d]", i), exp_entry.we, o_retire_we);
            if (exp_entry.we)
            begin
                check_reg($sformatf("o_retire_rd[%0d]", i), exp_entry.rd, o_retire_rd);
                check_word($sformatf("o_retire_data[%0d]", i), exp_entry.data, o_retire_data);
            end
        end

        if (inv_seen != INV_COUNT)
            report_failure($sformatf("saw %0d invalid-instruction pulses, expected %0d",
                                     inv_seen, INV_COUNT));

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_mini.f */
+incdir+dv
verilog/rv_pkg.sv
verilog/rv_issue_if.sv
verilog/rv_fetch_ctrl.sv
verilog/rv_pc_counter.sv
verilog/rv_decode.sv
verilog/rv_regs.sv
verilog/rv_execute.sv
verilog/rv_core.sv
dv/tb_rv_core.sv
